/* files.f */
msgq_pkg.sv
msgq_bus_regs.sv
msgq_ram.sv
msgq_inbound.sv
msgq_ram_arbiter.sv
msgq_outbound.sv
msgq_top.sv
msgq_properties.sv
msgq_checker.sv
tb_msgq.sv

/* msgq_bus_regs.sv */
/* Processor side of the message queue. Decodes the word-addressed bus into
   the register block and RAM port A, holds the processor-owned pointers and
   the control register, and drives the interrupt from status and control. */

`timescale 1ns/1ps

module msgq_bus_regs import msgq_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  bus_addr_t addr,
	input  logic      write_en,
	input  logic      read_en,
	input  word_t     write_data,
	output word_t     read_data,
	output ram_addr_t a_addr,
	output logic      a_we,
	output word_t     a_wdata,
	input  word_t     a_rdata,
	input  qptr_t     in_wr_ptr,
	input  qptr_t     out_rd_ptr,
	output qptr_t     in_rd_ptr,
	output qptr_t     out_wr_ptr,
	output logic      irq
);

	logic       reg_space;
	logic       reg_wr;
	bus_addr_t  addr_r;
	logic [1:0] control;
	logic [1:0] status;
	word_t      reg_rdata;

	// below RAM_BASE is the register block
	assign reg_space = (addr < RAM_BASE);
	assign reg_wr = write_en && reg_space;

	// RAM port A follows the bus directly
	assign a_addr = ram_addr_t'(addr - RAM_BASE);
	assign a_we = write_en && !reg_space;
	assign a_wdata = write_data;

	// address of the last read, picks the data source next cycle
	always_ff @(posedge clk) begin
		if (read_en) begin
			addr_r <= addr;
		end
	end

	// processor-owned pointers and control
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_rd_ptr <= '0;
			out_wr_ptr <= '0;
			control <= '0;
		end else if (reg_wr) begin
			case (addr[3:0])
				REG_IN_RD: in_rd_ptr <= write_data[QUEUE_ADDR_BITS-2:0];
				REG_OUT_WR: out_wr_ptr <= write_data[QUEUE_ADDR_BITS-2:0];
				REG_CONTROL: control <= write_data[1:0];
				// hardware-owned pointers and status drop the write
				default: ;
			endcase
		end
	end

	// bit 0 inbound has data, bit 1 outbound drained
	assign status[0] = (in_wr_ptr != in_rd_ptr);
	assign status[1] = (out_wr_ptr == out_rd_ptr);

	// enabled sources only
	assign irq = |(status & control);

	always_comb begin
		case (addr_r[3:0])
			REG_IN_RD: reg_rdata = word_t'(in_rd_ptr);
			REG_IN_WR: reg_rdata = word_t'(in_wr_ptr);
			REG_OUT_RD: reg_rdata = word_t'(out_rd_ptr);
			REG_OUT_WR: reg_rdata = word_t'(out_wr_ptr);
			REG_CONTROL: reg_rdata = word_t'(control);
			REG_STATUS: reg_rdata = word_t'(status);
			default: reg_rdata = '0;
		endcase
	end

	// RAM data is already one cycle late from the registered read
	assign read_data = (addr_r < RAM_BASE) ? reg_rdata : a_rdata;

endmodule

/* msgq_checker.sv */
/* Testbench checker for the message queue. Compares bus reads against values
   posted by the testbench and matches every outbound stream word against a
   reference queue built from the processor's own writes. */

`timescale 1ns/1ps

module msgq_checker import msgq_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input bus_addr_t addr,
	input logic      write_en,
	input word_t     write_data,
	input logic      read_en,
	input word_t     read_data,
	input logic      outbound_valid,
	input word_t     outbound_data,
	input logic      outbound_ready
);

	int    read_errors = 0;
	int    stream_errors = 0;
	int    other_errors = 0;
	string cur_test = "none";
	// posted reads, oldest first
	word_t exp_q[$];
	string name_q[$];
	logic  pend = 1'b0;
	word_t pend_exp;
	string pend_name;
	// shadow of the outbound ring
	word_t slots [QUEUE_DEPTH];
	qptr_t wr_model;
	word_t ref_q[$];

	task automatic set_test(string n);
		cur_test = n;
	endtask

	task automatic expect_read(string n, word_t e);
		name_q.push_back(n);
		exp_q.push_back(e);
	endtask

	task automatic check_value(string n, word_t e, word_t a);
		if (e !== a) begin
			other_errors++;
			$display("error: %s expected %0h actual %0h", n, e, a);
		end
	endtask

	task automatic final_check();
		if (ref_q.size() != 0) begin
			other_errors++;
			$display("%0d outbound words were queued but never left on the stream",
				ref_q.size());
		end
	endtask

	// a read strobe takes the next posted value
	always @(posedge clk) begin
		if (read_en && exp_q.size() > 0) begin
			pend <= 1'b1;
			pend_exp <= exp_q.pop_front();
			pend_name <= name_q.pop_front();
		end else begin
			pend <= 1'b0;
		end
	end

	// read data is settled mid cycle
	always @(negedge clk) begin
		if (pend && read_data !== pend_exp) begin
			read_errors++;
			$display("error: %s read expected %0h actual %0h", pend_name, pend_exp, read_data);
		end
	end

	always @(posedge clk) begin : watch_outbound
		qptr_t p;
		qptr_t new_ptr;
		word_t e;
		if (!rst_n) begin
			wr_model = '0;
		end else begin
			if (write_en && addr >= RAM_BASE + QUEUE_DEPTH
				&& addr < RAM_BASE + 2 * QUEUE_DEPTH) begin
				slots[qptr_t'(addr - RAM_BASE - QUEUE_DEPTH)] = write_data;
			end
			// pointer write publishes slots up to the new value
			if (write_en && addr == bus_addr_t'(REG_OUT_WR)) begin
				new_ptr = write_data[QUEUE_ADDR_BITS-2:0];
				p = wr_model;
				while (p != new_ptr) begin
					ref_q.push_back(slots[p]);
					p = p + qptr_t'(1);
				end
				wr_model = new_ptr;
			end
			if (outbound_valid && outbound_ready) begin
				if (ref_q.size() == 0) begin
					stream_errors++;
					$display("outbound word %0h left the DUT with nothing queued", outbound_data);
				end else begin
					e = ref_q.pop_front();
					if (outbound_data !== e) begin
						stream_errors++;
						$display("error: %s outbound expected %0h actual %0h",
							cur_test, e, outbound_data);
					end
				end
			end
		end
	end

endmodule

/* msgq_inbound.sv */
/* Inbound stream writer. Takes one word from the stream, holds it while it
   waits for RAM port B, and bumps the inbound write pointer once the word is
   in the ring. inbound_ready drops while busy or when the ring is full. */

`timescale 1ns/1ps

module msgq_inbound import msgq_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  inbound_valid,
	input  word_t inbound_data,
	output logic  inbound_ready,
	input  qptr_t in_rd_ptr,
	output logic  in_req,
	input  logic  in_gnt,
	output word_t in_wdata,
	output qptr_t in_wr_ptr
);

	in_state_e state;
	qptr_t     wr_ptr_next;
	logic      accept;

	// wraps at the ring depth through the pointer width
	assign wr_ptr_next = in_wr_ptr + qptr_t'(1);

	// full when the next slot would meet the read pointer
	assign inbound_ready = (state == IN_IDLE) && (wr_ptr_next != in_rd_ptr);
	assign accept = inbound_valid && inbound_ready;

	// asks for port B until the grant cycle ends
	assign in_req = (state == IN_REQ);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IN_IDLE;
			in_wr_ptr <= '0;
		end else begin
			case (state)
				IN_IDLE: if (accept) state <= IN_REQ;
				// RAM write lands on the edge closing the grant
				IN_REQ: if (in_gnt) state <= IN_WRITE;
				IN_WRITE: begin
					in_wr_ptr <= wr_ptr_next;
					state <= IN_IDLE;
				end
				default: state <= IN_IDLE;
			endcase
		end
	end

	// word held for the arbiter
	always_ff @(posedge clk) begin
		if (accept) begin
			in_wdata <= inbound_data;
		end
	end

endmodule

/* msgq_outbound.sv */
/* Outbound stream stage. Notices words the processor has queued, fetches one
   through the RAM arbiter and presents it on the stream with valid/ready.
   The read pointer moves on the transfer edge, one word in flight at a time. */

`timescale 1ns/1ps

module msgq_outbound import msgq_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  qptr_t out_wr_ptr,
	output qptr_t out_rd_ptr,
	output logic  out_req,
	input  logic  out_gnt,
	input  word_t b_rdata,
	output logic  outbound_valid,
	output word_t outbound_data,
	input  logic  outbound_ready
);

	out_state_e state;
	word_t      data_r;

	assign out_req = (state == OUT_REQ);
	assign outbound_valid = (state == OUT_VALID);
	// stays put until the next capture
	assign outbound_data = data_r;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= OUT_IDLE;
			out_rd_ptr <= '0;
		end else begin
			case (state)
				// pending work when the pointers differ
				OUT_IDLE: if (out_rd_ptr != out_wr_ptr) state <= OUT_REQ;
				OUT_REQ: if (out_gnt) state <= OUT_WAIT;
				// registered RAM read shows up here
				OUT_WAIT: state <= OUT_VALID;
				OUT_VALID: begin
					if (outbound_ready) begin
						out_rd_ptr <= out_rd_ptr + qptr_t'(1);
						state <= OUT_IDLE;
					end
				end
				default: state <= OUT_IDLE;
			endcase
		end
	end

	// capture the fetched word
	always_ff @(posedge clk) begin
		if (state == OUT_WAIT) begin
			data_r <= b_rdata;
		end
	end

endmodule

/* msgq_pkg.sv */
/* Shared widths, queue geometry, register offsets and FSM state types for
   the message queue. Each module pulls it in with a wildcard import in its
   header. */

package msgq_pkg;

	// geometry: two rings share one RAM
	localparam int QUEUE_ADDR_BITS = 8;
	// slots per ring, one always left empty
	localparam int QUEUE_DEPTH = 1 << (QUEUE_ADDR_BITS - 1);

	typedef logic [31:0] word_t;
	typedef logic [15:0] bus_addr_t;
	// spans inbound and outbound rings
	typedef logic [QUEUE_ADDR_BITS-1:0] ram_addr_t;
	// index within one ring
	typedef logic [QUEUE_ADDR_BITS-2:0] qptr_t;

	// first bus word of the queue RAM
	localparam bus_addr_t RAM_BASE = 16'h0400;

	// register map, low four address bits
	localparam logic [3:0] REG_IN_RD = 4'd0;
	localparam logic [3:0] REG_IN_WR = 4'd1;
	localparam logic [3:0] REG_OUT_RD = 4'd2;
	localparam logic [3:0] REG_OUT_WR = 4'd3;
	localparam logic [3:0] REG_CONTROL = 4'd4;
	localparam logic [3:0] REG_STATUS = 4'd5;

	typedef enum logic [1:0] {IN_IDLE, IN_REQ, IN_WRITE} in_state_e;

	typedef enum logic [1:0] {OUT_IDLE, OUT_REQ, OUT_WAIT, OUT_VALID} out_state_e;

	typedef enum logic [1:0] {ARB_IDLE, ARB_IN, ARB_OUT} arb_state_e;

endpackage

/* msgq_properties.sv */
/* Assertions on the message queue top level, bound into msgq_top. Covers the
   outbound stream handshake and the quiet outputs while reset is held. */

`timescale 1ns/1ps

module msgq_properties import msgq_pkg::*; (
	input logic  clk,
	input logic  rst_n,
	input logic  outbound_valid,
	input word_t outbound_data,
	input logic  outbound_ready,
	input logic  irq,
	input logic  b_we
);

	// assertion failures so far
	int failures = 0;

	// stalled word must not move or vanish
	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		outbound_valid && !outbound_ready |=> outbound_valid && $stable(outbound_data))
		else begin
			failures++;
			$error("outbound valid or data changed while the stream was stalled");
		end

	// nothing active straight out of a reset edge
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !irq && !outbound_valid && !b_we)
		else begin
			failures++;
			$error("irq, outbound_valid or port B write active during reset");
		end

endmodule

bind msgq_top msgq_properties u_props (
	.clk(clk),
	.rst_n(rst_n),
	.outbound_valid(outbound_valid),
	.outbound_data(outbound_data),
	.outbound_ready(outbound_ready),
	.irq(irq),
	.b_we(b_we)
);

/* msgq_ram.sv */
/* Dual-port word RAM holding both rings. Each port reads with one cycle of
   latency and writes on the clock edge; the pointers keep the processor and
   the stream hardware in different slots. */

`timescale 1ns/1ps

module msgq_ram import msgq_pkg::*; (
	input  logic      clk,
	input  ram_addr_t a_addr,
	input  logic      a_we,
	input  word_t     a_wdata,
	output word_t     a_rdata,
	input  ram_addr_t b_addr,
	input  logic      b_we,
	input  word_t     b_wdata,
	output word_t     b_rdata
);

	// inbound ring low half, outbound ring high half
	word_t mem [2*QUEUE_DEPTH];

	always_ff @(posedge clk) begin
		// port A, processor
		if (a_we) begin
			mem[a_addr] <= a_wdata;
		end
		a_rdata <= mem[a_addr];

		// port B, arbitrated stream side
		if (b_we) begin
			mem[b_addr] <= b_wdata;
		end
		b_rdata <= mem[b_addr];
	end

endmodule

/* msgq_ram_arbiter.sv */
/* Round-robin owner of RAM port B shared by the inbound writer and the
   outbound reader. A grant lasts one cycle; on a tie the side that did not
   win last time goes first. Also forms the port B address and write strobe. */

`timescale 1ns/1ps

module msgq_ram_arbiter import msgq_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_req,
	input  word_t     in_wdata,
	input  qptr_t     in_wr_ptr,
	output logic      in_gnt,
	input  logic      out_req,
	input  qptr_t     out_rd_ptr,
	output logic      out_gnt,
	output ram_addr_t b_addr,
	output logic      b_we,
	output word_t     b_wdata
);

	arb_state_e state;
	// 0 inbound, 1 outbound
	logic       last_out;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ARB_IDLE;
			last_out <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (in_req && (!out_req || last_out)) begin
						state <= ARB_IN;
						last_out <= 1'b0;
					end else if (out_req) begin
						state <= ARB_OUT;
						last_out <= 1'b1;
					end
				end
				// single-cycle grants
				default: state <= ARB_IDLE;
			endcase
		end
	end

	assign in_gnt = (state == ARB_IN);
	assign out_gnt = (state == ARB_OUT);

	// outbound ring sits above the inbound one
	assign b_addr = out_gnt ? ram_addr_t'(QUEUE_DEPTH) + ram_addr_t'(out_rd_ptr)
		: ram_addr_t'(in_wr_ptr);
	assign b_we = in_gnt;
	assign b_wdata = in_wdata;

endmodule

/* msgq_top.sv */
/* Top level of the bidirectional message queue. Connects the processor bus
   side, the shared queue RAM with its port B arbiter, the inbound writer and
   the outbound stream stage. */

`timescale 1ns/1ps

module msgq_top import msgq_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	// processor bus
	input  bus_addr_t addr,
	input  logic      write_en,
	input  logic      read_en,
	input  word_t     write_data,
	output word_t     read_data,
	// stream in
	input  logic      inbound_valid,
	input  word_t     inbound_data,
	output logic      inbound_ready,
	// stream out
	output logic      outbound_valid,
	output word_t     outbound_data,
	input  logic      outbound_ready,
	output logic      irq
);

	// port A
	ram_addr_t a_addr;
	logic      a_we;
	word_t     a_wdata;
	word_t     a_rdata;
	// port B
	ram_addr_t b_addr;
	logic      b_we;
	word_t     b_wdata;
	word_t     b_rdata;
	// pointers, one owner each
	qptr_t     in_rd_ptr;
	qptr_t     in_wr_ptr;
	qptr_t     out_rd_ptr;
	qptr_t     out_wr_ptr;
	// arbiter handshakes
	logic      in_req;
	logic      in_gnt;
	word_t     in_wdata;
	logic      out_req;
	logic      out_gnt;

	msgq_bus_regs u_bus_regs (
		.clk(clk), .rst_n(rst_n), .addr(addr), .write_en(write_en),
		.read_en(read_en), .write_data(write_data), .read_data(read_data),
		.a_addr(a_addr), .a_we(a_we), .a_wdata(a_wdata), .a_rdata(a_rdata),
		.in_wr_ptr(in_wr_ptr), .out_rd_ptr(out_rd_ptr), .in_rd_ptr(in_rd_ptr),
		.out_wr_ptr(out_wr_ptr), .irq(irq)
	);

	msgq_ram u_ram (
		.clk(clk), .a_addr(a_addr), .a_we(a_we), .a_wdata(a_wdata),
		.a_rdata(a_rdata), .b_addr(b_addr), .b_we(b_we), .b_wdata(b_wdata),
		.b_rdata(b_rdata)
	);

	msgq_inbound u_inbound (
		.clk(clk), .rst_n(rst_n), .inbound_valid(inbound_valid),
		.inbound_data(inbound_data), .inbound_ready(inbound_ready),
		.in_rd_ptr(in_rd_ptr), .in_req(in_req), .in_gnt(in_gnt),
		.in_wdata(in_wdata), .in_wr_ptr(in_wr_ptr)
	);

	msgq_ram_arbiter u_arbiter (
		.clk(clk), .rst_n(rst_n), .in_req(in_req), .in_wdata(in_wdata),
		.in_wr_ptr(in_wr_ptr), .in_gnt(in_gnt), .out_req(out_req),
		.out_rd_ptr(out_rd_ptr), .out_gnt(out_gnt), .b_addr(b_addr),
		.b_we(b_we), .b_wdata(b_wdata)
	);

	msgq_outbound u_outbound (
		.clk(clk), .rst_n(rst_n), .out_wr_ptr(out_wr_ptr),
		.out_rd_ptr(out_rd_ptr), .out_req(out_req), .out_gnt(out_gnt),
		.b_rdata(b_rdata), .outbound_valid(outbound_valid),
		.outbound_data(outbound_data), .outbound_ready(outbound_ready)
	);

endmodule

/* run.sh */
#!/bin/sh
# build and run the message queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_msgq \
	-f files.f -o sim_msgq > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/sim_msgq > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* tb_msgq.sv */
/* Top-level testbench for the message queue. Runs a table of tests through
   the processor bus and both stream ports, with random stream gaps and
   stalls; msgq_checker does the comparing. */

`timescale 1ns/1ps

module tb_msgq import msgq_pkg::*; ();

	typedef enum {OP_RESET, OP_INBOUND, OP_FULL, OP_OUTBOUND, OP_IRQ, OP_READONLY} op_e;
	typedef struct {
		string name;
		op_e   op;
		int    count;
		word_t start;
	} step_t;

	// slots freed after the ring fills
	localparam int FREE_SLOTS = 5;

	logic      clk;
	logic      rst_n;
	bus_addr_t addr;
	logic      write_en;
	logic      read_en;
	word_t     write_data;
	word_t     read_data;
	logic      inbound_valid;
	word_t     inbound_data;
	logic      inbound_ready;
	logic      outbound_valid;
	word_t     outbound_data;
	logic      outbound_ready;
	logic      irq;

	step_t       steps[$];
	logic [31:0] lfsr;
	// pointer model
	qptr_t       in_wr_m;
	qptr_t       in_rd_m;
	qptr_t       out_wr_m;

	msgq_top u_dut (
		.clk(clk), .rst_n(rst_n), .addr(addr), .write_en(write_en),
		.read_en(read_en), .write_data(write_data), .read_data(read_data),
		.inbound_valid(inbound_valid), .inbound_data(inbound_data),
		.inbound_ready(inbound_ready), .outbound_valid(outbound_valid),
		.outbound_data(outbound_data), .outbound_ready(outbound_ready), .irq(irq)
	);

	msgq_checker u_chk (
		.clk(clk), .rst_n(rst_n), .addr(addr), .write_en(write_en),
		.write_data(write_data), .read_en(read_en), .read_data(read_data),
		.outbound_valid(outbound_valid), .outbound_data(outbound_data),
		.outbound_ready(outbound_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois lfsr for x^32+x^22+x^2+x+1
	function automatic logic rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	task automatic add_step(string n, op_e op, int count, word_t start);
		step_t s;
		s.name = n;
		s.op = op;
		s.count = count;
		s.start = start;
		steps.push_back(s);
	endtask

	task automatic bus_write(bus_addr_t a, word_t d);
		addr = a;
		write_data = d;
		write_en = 1'b1;
		@(posedge clk);
		#1 write_en = 1'b0;
	endtask

	task automatic bus_read(bus_addr_t a, output word_t d);
		addr = a;
		read_en = 1'b1;
		@(posedge clk);
		#1 read_en = 1'b0;
		@(negedge clk);
		d = read_data;
		@(posedge clk);
		#1;
	endtask

	task automatic check_read(string n, bus_addr_t a, word_t e);
		word_t d;
		u_chk.expect_read(n, e);
		bus_read(a, d);
	endtask

	// poll until the register shows the value
	task automatic poll_reg(bus_addr_t a, word_t e);
		word_t d;
		d = ~e;
		while (d != e) bus_read(a, d);
	endtask

	task automatic send_words(int n, word_t start);
		logic rdy;
		for (int i = 0; i < n; i++) begin
			if (rand_bit()) begin
				inbound_valid = 1'b0;
				@(posedge clk);
				#1;
			end
			inbound_valid = 1'b1;
			inbound_data = start + word_t'(i);
			rdy = 1'b0;
			while (!rdy) begin
				@(negedge clk);
				rdy = inbound_ready;
				@(posedge clk);
				#1;
			end
		end
		inbound_valid = 1'b0;
	endtask

	// stream n words in, wait for the pointer, read them back
	task automatic fill_inbound(string n, int cnt, word_t start);
		qptr_t np;
		np = in_wr_m + qptr_t'(cnt);
		send_words(cnt, start);
		poll_reg(bus_addr_t'(REG_IN_WR), word_t'(np));
		for (int i = 0; i < cnt; i++) begin
			check_read(n, RAM_BASE + bus_addr_t'(qptr_t'(in_wr_m + qptr_t'(i))),
				start + word_t'(i));
		end
		in_wr_m = np;
		check_read(n, bus_addr_t'(REG_IN_WR), word_t'(in_wr_m));
	endtask

	task automatic release_inbound(string n);
		check_read(n, bus_addr_t'(REG_STATUS), 32'd3);
		bus_write(bus_addr_t'(REG_IN_RD), word_t'(in_wr_m));
		in_rd_m = in_wr_m;
		check_read(n, bus_addr_t'(REG_STATUS), 32'd2);
	endtask

	// offered word must stay refused
	task automatic hold_full(string n);
		inbound_valid = 1'b1;
		inbound_data = 32'hdead_0000;
		repeat (8) begin
			@(negedge clk);
			u_chk.check_value({n, " inbound_ready"}, 32'd0, word_t'(inbound_ready));
			@(posedge clk);
			#1;
		end
		inbound_valid = 1'b0;
	endtask

	task automatic run_outbound(string n, int cnt, word_t start);
		for (int i = 0; i < cnt; i++) begin
			bus_write(RAM_BASE + QUEUE_DEPTH + bus_addr_t'(qptr_t'(out_wr_m + qptr_t'(i))),
				start + word_t'(i));
		end
		out_wr_m = out_wr_m + qptr_t'(cnt);
		bus_write(bus_addr_t'(REG_OUT_WR), word_t'(out_wr_m));
		// first word is still in flight, so outbound empty reads clear
		check_read(n, bus_addr_t'(REG_STATUS), word_t'(in_wr_m != in_rd_m));
		poll_reg(bus_addr_t'(REG_OUT_RD), word_t'(out_wr_m));
		check_read(n, bus_addr_t'(REG_OUT_RD), word_t'(out_wr_m));
		check_read(n, bus_addr_t'(REG_STATUS), 32'd2);
	endtask

	task automatic irq_sweep(string n, logic [1:0] st);
		for (int c = 0; c < 4; c++) begin
			bus_write(bus_addr_t'(REG_CONTROL), word_t'(c));
			check_read(n, bus_addr_t'(REG_CONTROL), word_t'(c));
			@(negedge clk);
			u_chk.check_value({n, " irq"}, word_t'(|(st & c[1:0])), word_t'(irq));
			@(posedge clk);
			#1;
		end
		bus_write(bus_addr_t'(REG_CONTROL), 32'd0);
	endtask

	task automatic run_step(step_t s);
		u_chk.set_test(s.name);
		case (s.op)
			OP_RESET: begin
				u_chk.check_value("irq", 32'd0, word_t'(irq));
				u_chk.check_value("outbound_valid", 32'd0, word_t'(outbound_valid));
				u_chk.check_value("inbound_ready", 32'd1, word_t'(inbound_ready));
				for (int r = 0; r < 6; r++) begin
					check_read(s.name, bus_addr_t'(r), (r == 5) ? 32'd2 : 32'd0);
				end
			end
			OP_INBOUND: begin
				fill_inbound(s.name, s.count, s.start);
				release_inbound(s.name);
			end
			OP_FULL: begin
				fill_inbound(s.name, s.count, s.start);
				hold_full(s.name);
				in_rd_m = in_rd_m + qptr_t'(FREE_SLOTS);
				bus_write(bus_addr_t'(REG_IN_RD), word_t'(in_rd_m));
				fill_inbound(s.name, FREE_SLOTS, s.start + word_t'(s.count));
				hold_full(s.name);
				release_inbound(s.name);
			end
			OP_OUTBOUND: run_outbound(s.name, s.count, s.start);
			OP_IRQ: begin
				irq_sweep(s.name, 2'b10);
				fill_inbound(s.name, 1, s.start);
				irq_sweep(s.name, 2'b11);
				release_inbound(s.name);
			end
			OP_READONLY: begin
				bus_write(bus_addr_t'(REG_IN_WR), 32'h55);
				bus_write(bus_addr_t'(REG_OUT_RD), 32'h33);
				bus_write(bus_addr_t'(REG_STATUS), 32'hff);
				check_read(s.name, bus_addr_t'(REG_IN_WR), word_t'(in_wr_m));
				check_read(s.name, bus_addr_t'(REG_OUT_RD), word_t'(out_wr_m));
				check_read(s.name, bus_addr_t'(REG_STATUS), 32'd2);
			end
			default: u_chk.check_value("unknown step kind", 32'd0, 32'd1);
		endcase
	endtask

	// random ready stalls on the outbound stream
	initial begin
		@(posedge rst_n);
		forever begin
			@(posedge clk);
			#1 outbound_ready = rand_bit() | rand_bit();
		end
	end

	initial begin : watchdog
		int words;
		int limit;
		#1;
		words = FREE_SLOTS;
		foreach (steps[i]) words += steps[i].count;
		limit = words * 40 + 2000;
		repeat (limit) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", limit);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : main
		int total;
		rst_n = 1'b0;
		addr = '0;
		write_en = 1'b0;
		read_en = 1'b0;
		write_data = '0;
		inbound_valid = 1'b0;
		inbound_data = '0;
		outbound_ready = 1'b0;
		lfsr = 32'd88972;
		in_wr_m = '0;
		in_rd_m = '0;
		out_wr_m = '0;
		add_step("reset_values", OP_RESET, 0, 32'h0);
		add_step("inbound_path", OP_INBOUND, 20, 32'h1000_0000);
		add_step("inbound_full", OP_FULL, 127, 32'h2000_0000);
		add_step("outbound_path", OP_OUTBOUND, 100, 32'h3000_0000);
		add_step("outbound_wrap", OP_OUTBOUND, 60, 32'h4000_0000);
		add_step("interrupts", OP_IRQ, 1, 32'h5000_0000);
		add_step("read_only", OP_READONLY, 0, 32'h0);
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		foreach (steps[i]) run_step(steps[i]);
		repeat (4) @(posedge clk);
		u_chk.final_check();
		total = u_chk.read_errors + u_chk.stream_errors + u_chk.other_errors
			+ u_dut.u_props.failures;
		$display("errors: read %0d, stream %0d, other %0d, assertion %0d",
			u_chk.read_errors, u_chk.stream_errors, u_chk.other_errors,
			u_dut.u_props.failures);
		if (total == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
